// File: rtl/pr_pkg.sv
package pr_pkg;

	// Bit 0 is the MSB, bit numbering as on the schematics
	typedef logic [0:15] word_t;

	// User register address, 0 selects R0
	typedef logic [2:0] reg_addr_t;

	localparam int NUM_UREGS = 7; // R1..R7

	// CPU flag positions in R0
	localparam int F_Z = 0; // Zero
	localparam int F_M = 1; // Minus
	localparam int F_V = 2; // Overflow, sticky
	localparam int F_C = 3; // Carry
	localparam int F_L = 4; // Less
	localparam int F_E = 5; // Equal
	localparam int F_G = 6; // Greater
	localparam int F_Y = 7; // Extension Y
	localparam int F_X = 8; // Extension X

	localparam int R0_PROT_LAST = 7; // R0[0:7] guarded by Q

	typedef struct packed {
		reg_addr_t addr; // Register address
		logic w_r;       // W -> addressed register
		logic lpc;       // W -> R0, all bits
		logic rpc;       // R0 -> L
		logic blr;       // R0 >> 8 -> L
		logic w_bar;     // W -> Q, BS, NB
		logic w_rba;     // RB[10:15]
		logic w_rbb;     // RB[4:9]
		logic w_rbc;     // RB[0:3]
		logic clm;       // Master clear
		logic zer_sp;    // Software clear
	} pr_ctl_t;

	typedef struct packed {
		logic zs;      // ALU result zero
		logic s_1;     // Sign extension bit
		logic s0;      // Result sign
		logic carry;
		logic ovf;
		logic aryt;    // Arithmetic compare mode
		logic exy;
		logic exx;
		logic ust_z;   // Flag update strobes
		logic ust_mc;
		logic ust_v;
		logic ust_leg;
		logic ust_y;
		logic ust_x;
	} alu_flags_t;

	typedef enum logic [1:0] {KI_RZ, KI_SR, KI_RB, KI_ZP} ki_sel_t;

endpackage

// File: rtl/ureg_write_dec.sv
`timescale 1ns/1ps

module ureg_write_dec
	import pr_pkg::*;
(
	input logic clk_sys,               // Only for checking
	input reg_addr_t addr,
	input logic w_r,
	output logic [1:NUM_UREGS] we      // we[i] loads Ri
);

	// One enable per user register
	// R0 is left to r0_flags
	always_comb begin
		we = '0;
		for (int i = 1; i <= NUM_UREGS; i++) begin
			if (w_r && (addr == reg_addr_t'(i))) begin
				we[i] = 1'b1;
			end
		end
	end

	// No enable without w_r, never two at once
	a_we_onehot: assert property (
		@(posedge clk_sys) $onehot0(we) && (w_r || (we == '0))
	);

endmodule

// File: rtl/ureg_word.sv
`timescale 1ns/1ps

module ureg_word
	import pr_pkg::*;
(
	input logic clk_sys,
	input logic rst,
	input logic we,    // Load strobe from the decoder
	input word_t d,    // W bus
	output word_t q
);

	// Plain 16-bit register
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			q <= '0;
		end else if (we) begin
			q <= d;
		end
	end

endmodule

// File: rtl/ureg_read_sel.sv
`timescale 1ns/1ps

module ureg_read_sel
	import pr_pkg::*;
(
	input word_t bank [1:NUM_UREGS], // R1..R7
	input word_t r0,
	input reg_addr_t addr,
	input logic rpc,                 // Force R0 out
	input logic blr,                 // Block mode
	output word_t l
);

	logic sel_r0;

	// R0 when addressed directly or forced by RPC
	assign sel_r0 = rpc || (addr == '0);

	always_comb begin
		if (blr) begin
			// R0 shifted right by 8
			l = {8'h00, r0[0:7]};
		end else if (sel_r0) begin
			l = r0;
		end else begin
			l = bank[addr]; // Addr is 1..7 here
		end
	end

endmodule

// File: rtl/r0_flags.sv
`timescale 1ns/1ps

module r0_flags
	import pr_pkg::*;
(
	input logic clk_sys,
	input logic rst,
	input word_t w,          // W bus
	input reg_addr_t addr,
	input logic w_r,
	input logic lpc,         // Full load
	input alu_flags_t alu,
	input logic v_clr,       // Clears V
	input logic q,           // System flag, protects R0[0:7]
	input logic zer,         // Zero clear from sys_regs
	output word_t r0
);

	word_t nxt;
	logic wr0;      // User write to R0
	logic leg_l;
	logic leg_g;

	assign wr0 = w_r && (addr == '0);

	// L and G depend on compare mode
	always_comb begin
		if (alu.aryt) begin
			leg_l = alu.s_1;
			leg_g = ~alu.zs & ~alu.s_1;
		end else begin
			leg_l = ~alu.carry;            // Logic compare, borrow
			leg_g = alu.carry & ~alu.zs;
		end
	end

	// Flags first, loads override whatever bits they touch
	always_comb begin
		nxt = r0;

		if (alu.ust_z) begin
			nxt[F_Z] = alu.zs;
		end
		if (alu.ust_mc) begin
			nxt[F_M] = alu.s0;
			nxt[F_C] = alu.carry;
		end
		if (alu.ust_v && alu.ovf) nxt[F_V] = 1'b1; // Sticky
		if (v_clr) nxt[F_V] = 1'b0;                 // Clear beats set
		if (alu.ust_leg) begin
			nxt[F_L] = leg_l;
			nxt[F_E] = alu.zs;
			nxt[F_G] = leg_g;
		end
		if (alu.ust_y) nxt[F_Y] = alu.exy;
		if (alu.ust_x) nxt[F_X] = alu.exx;

		// Upper user part always writable
		if (wr0) begin
			nxt[R0_PROT_LAST+1:15] = w[R0_PROT_LAST+1:15];
			if (!q) begin
				nxt[0:R0_PROT_LAST] = w[0:R0_PROT_LAST];
			end
		end

		if (lpc) begin
			nxt = w;
		end

		// Zero clear wins over everything
		if (zer) begin
			nxt = '0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			r0 <= '0;
		end else begin
			r0 <= nxt;
		end
	end

	// LPC and a register write to R0 come from different instructions
	a_lpc_wr0: assert property (
		@(posedge clk_sys) disable iff (rst) !(lpc && wr0)
	);

endmodule

// File: rtl/sys_regs.sv
`timescale 1ns/1ps

module sys_regs
	import pr_pkg::*;
(
	input logic clk_sys,
	input logic rst,
	input word_t w,
	input logic w_bar,     // W -> Q, BS, NB
	input logic w_rba,
	input logic w_rbb,
	input logic w_rbc,
	input logic clm,       // Master clear
	input logic zer_sp,    // Software clear
	output logic q,
	output logic bs,
	output logic zer,
	output logic [0:3] nb, // Block number
	output word_t rb       // Binary load register
);

	assign zer = clm | zer_sp; // Shared with R0

	// Q drops on either clear
	always_ff @(posedge clk_sys) begin
		if (rst || zer) begin
			q <= 1'b0;
		end else if (w_bar) begin
			q <= w[10];
		end
	end

	// BS and NB only on master clear
	always_ff @(posedge clk_sys) begin
		if (rst || clm) begin
			bs <= 1'b0;
			nb <= '0;
		end else if (w_bar) begin
			bs <= w[11];
			nb <= w[12:15];
		end
	end

	// RB loaded in three independent fields
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rb <= '0;
		end else begin
			if (w_rbc) rb[0:3] <= w[12:15];
			if (w_rbb) rb[4:9] <= w[10:15];
			if (w_rba) rb[10:15] <= w[10:15];
		end
	end

endmodule

// File: rtl/ki_bus.sv
`timescale 1ns/1ps

module ki_bus
	import pr_pkg::*;
(
	input ki_sel_t sel,
	input word_t rz,
	input word_t zp,
	input word_t rb,
	input logic [0:9] rs,  // Interrupt status bits
	input logic q,
	input logic bs,
	input logic [0:3] nb,
	output word_t ki
);

	word_t sr;

	// Status word: RS, Q, BS, NB
	assign sr = {rs, q, bs, nb};

	always_comb begin
		case (sel)
			KI_RZ: ki = rz;
			KI_SR: ki = sr;
			KI_RB: ki = rb;
			default: ki = zp; // KI_ZP
		endcase
		// Select must be driven
		a_sel_known: assert final (!$isunknown(sel));
	end

endmodule

// File: rtl/pr.sv
`timescale 1ns/1ps

module pr
	import pr_pkg::*;
(
	input logic clk_sys,
	input logic rst,
	input word_t w,            // W bus
	input pr_ctl_t ctl,
	input alu_flags_t alu,
	input logic v_clr,
	input ki_sel_t ki_sel,
	input word_t rz,           // RZ bus
	input word_t zp,           // ZP bus
	input logic [0:9] rs,
	output word_t l,           // L bus
	output word_t r0,          // R0 with flags
	output logic q,            // System flag
	output word_t ki           // KI bus
);

	logic [1:NUM_UREGS] ureg_we;
	word_t ureg_bank [1:NUM_UREGS];
	logic bs;
	logic zer;                 // CLM or ZER*SP
	logic [0:3] nb;
	word_t rb;

	ureg_write_dec ureg_write_dec_i (
		.clk_sys(clk_sys),
		.addr(ctl.addr),
		.w_r(ctl.w_r),
		.we(ureg_we)
	);

	// R1..R7
	for (genvar i = 1; i <= NUM_UREGS; i++) begin : g_ureg
		ureg_word ureg_word_i (
			.clk_sys(clk_sys),
			.rst(rst),
			.we(ureg_we[i]),
			.d(w),
			.q(ureg_bank[i])
		);
	end

	ureg_read_sel ureg_read_sel_i (
		.bank(ureg_bank),
		.r0(r0),
		.addr(ctl.addr),
		.rpc(ctl.rpc),
		.blr(ctl.blr),
		.l(l)
	);

	r0_flags r0_flags_i (
		.clk_sys(clk_sys),
		.rst(rst),
		.w(w),
		.addr(ctl.addr),
		.w_r(ctl.w_r),
		.lpc(ctl.lpc),
		.alu(alu),
		.v_clr(v_clr),
		.q(q),
		.zer(zer),
		.r0(r0)
	);

	sys_regs sys_regs_i (
		.clk_sys(clk_sys),
		.rst(rst),
		.w(w),
		.w_bar(ctl.w_bar),
		.w_rba(ctl.w_rba),
		.w_rbb(ctl.w_rbb),
		.w_rbc(ctl.w_rbc),
		.clm(ctl.clm),
		.zer_sp(ctl.zer_sp),
		.q(q),
		.bs(bs),
		.zer(zer),
		.nb(nb),
		.rb(rb)
	);

	ki_bus ki_bus_i (
		.sel(ki_sel),
		.rz(rz),
		.zp(zp),
		.rb(rb),
		.rs(rs),
		.q(q),
		.bs(bs),
		.nb(nb),
		.ki(ki)
	);

endmodule

// File: test/pr_tb.sv
`timescale 1ns/1ps

module pr_tb
	import pr_pkg::*;
();

	// Shadow copy of every register in the unit
	typedef struct packed {
		logic [1:NUM_UREGS][0:15] ureg;
		word_t r0;
		logic q;
		logic bs;
		logic [0:3] nb;
		word_t rb;
	} model_t;

	localparam int POLL_LIMIT = 8; // 2 ns polls over two clock periods

	logic clk_sys;
	logic rst;
	word_t w;
	pr_ctl_t ctl;
	alu_flags_t alu;
	logic v_clr;
	ki_sel_t ki_sel = KI_RZ; // Known from time zero
	word_t rz;
	word_t zp;
	logic [0:9] rs;
	word_t l;
	word_t r0;
	logic q;
	word_t ki;

	model_t model;
	logic checking = 1'b0;
	int cycle_cnt = 0;
	int check_cnt = 0;
	int err_cnt = 0;
	int test_cnt = 0;
	int test_fail_cnt = 0;
	int test_err_base = 0;
	int test_chk_base = 0;
	string test_name = "reset";
	logic [31:0] lfsr_state;

	pr dut_i (
		.clk_sys(clk_sys), .rst(rst), .w(w), .ctl(ctl), .alu(alu), .v_clr(v_clr),
		.ki_sel(ki_sel), .rz(rz), .zp(zp), .rs(rs), .l(l), .r0(r0), .q(q), .ki(ki)
	);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#4 clk_sys = 1'b1; // Rising edges at 4, 12, 20 ...
			#4 clk_sys = 1'b0;
		end
	end

	// Right-shift Galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	function automatic logic [31:0] take_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state); // One step per bit
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic word_t rand_word();
		logic [31:0] b;
		b = take_bits(16);
		return b[15:0];
	endfunction

	// Random address in 1..7
	function automatic reg_addr_t rand_uaddr();
		logic [31:0] b;
		b = take_bits(3);
		return (b[2:0] == 3'd0) ? 3'd7 : b[2:0];
	endfunction

	// Register state after one edge with the given inputs
	function automatic model_t next_state(model_t s, word_t wd, pr_ctl_t c, alu_flags_t a,
			logic vc);
		model_t n;
		word_t flg;
		logic zer;
		n = s;
		zer = c.clm | c.zer_sp;
		if (c.w_r && c.addr != 3'd0) n.ureg[c.addr] = wd;
		flg = s.r0; // Flag strobes act on the old R0
		if (a.ust_z) flg[F_Z] = a.zs;
		if (a.ust_mc) begin
			flg[F_M] = a.s0;
			flg[F_C] = a.carry;
		end
		if (a.ust_v && a.ovf) flg[F_V] = 1'b1;
		if (vc) flg[F_V] = 1'b0; // Clear wins
		if (a.ust_leg) begin
			flg[F_E] = a.zs;
			flg[F_L] = a.aryt ? a.s_1 : !a.carry;
			flg[F_G] = a.aryt ? (!a.zs && !a.s_1) : (a.carry && !a.zs);
		end
		if (a.ust_y) flg[F_Y] = a.exy;
		if (a.ust_x) flg[F_X] = a.exx;
		if (zer) begin
			n.r0 = '0;
		end else if (c.lpc) begin
			n.r0 = wd;
		end else if (c.w_r && c.addr == 3'd0) begin
			n.r0 = s.q ? {flg[0:7], wd[8:15]} : wd; // Q guards the flag byte
		end else begin
			n.r0 = flg;
		end
		if (zer) begin
			n.q = 1'b0;
		end else if (c.w_bar) begin
			n.q = wd[10];
		end
		if (c.clm) begin
			n.bs = 1'b0;
			n.nb = '0;
		end else if (c.w_bar) begin
			n.bs = wd[11];
			n.nb = wd[12:15];
		end
		if (c.w_rbc) n.rb[0:3] = wd[12:15];
		if (c.w_rbb) n.rb[4:9] = wd[10:15];
		if (c.w_rba) n.rb[10:15] = wd[10:15];
		return n;
	endfunction

	function automatic word_t expect_l(model_t s, pr_ctl_t c);
		if (c.blr) return {8'h00, s.r0[0:7]};
		if (c.rpc || c.addr == 3'd0) return s.r0;
		return s.ureg[c.addr];
	endfunction

	function automatic word_t expect_ki(model_t s, ki_sel_t sel, word_t rzv, word_t zpv,
			logic [0:9] rsv);
		case (sel)
			KI_RZ: return rzv;
			KI_SR: return {rsv, s.q, s.bs, s.nb}; // Status word
			KI_RB: return s.rb;
			default: return zpv;
		endcase
	endfunction

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (rst) begin
			model <= '0;
		end else begin
			model <= next_state(model, w, ctl, alu, v_clr);
		end
	end

	task automatic compare(string name, logic [15:0] got, logic [15:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERROR %s: got %h expected %h in %s, cycle %0d", name, got, exp,
				test_name, cycle_cnt);
		end
	endtask

	// Outputs are settled half a period before the next edge
	always @(negedge clk_sys) begin
		if (checking) begin
			compare("l", l, expect_l(model, ctl));
			compare("r0", r0, model.r0);
			compare("q", {15'b0, q}, {15'b0, model.q});
			compare("ki", ki, expect_ki(model, ki_sel, rz, zp, rs));
		end
	end

	task automatic abort_run(string why);
		$display("%s", why);
		$display("Test FAILED");
		$finish;
	endtask

	// Back 1 ns after the next rising edge
	task automatic next_cycle();
		int start;
		int polls;
		start = cycle_cnt;
		polls = 0;
		while (cycle_cnt == start) begin
			#2;
			polls++;
			if (polls > POLL_LIMIT) abort_run("No rising clock edge within one period");
		end
	endtask

	task automatic quiet_inputs();
		ctl = '0;
		alu = '0;
		v_clr = 1'b0;
	endtask

	task automatic begin_test(string name);
		test_name = name;
		test_err_base = err_cnt;
		test_chk_base = check_cnt;
	endtask

	task automatic end_test();
		int errs;
		errs = err_cnt - test_err_base;
		test_cnt++;
		if (errs != 0) test_fail_cnt++;
		$display("%s: %0d checks, %0d errors, %s", test_name, check_cnt - test_chk_base, errs,
			(errs == 0) ? "pass" : "fail");
	endtask

	initial begin
		logic [31:0] bits;
		rst = 1'b1;
		w = '0;
		rz = '0;
		zp = '0;
		rs = '0;
		quiet_inputs();
		lfsr_state = 32'd90199;
		#1; // Odd offset keeps polls off the edges
		for (int i = 0; i < 5; i++) next_cycle();
		rst = 1'b0;
		checking = 1'b1;

		begin_test("user registers");
		for (int a = 1; a <= NUM_UREGS; a++) begin
			ctl.addr = reg_addr_t'(a); // All zero after reset
			next_cycle();
		end
		ctl.w_r = 1'b1;
		for (int i = 0; i < 24; i++) begin
			ctl.addr = rand_uaddr();
			w = rand_word();
			next_cycle();
		end
		ctl.w_r = 1'b0;
		for (int a = 1; a <= NUM_UREGS; a++) begin
			ctl.addr = reg_addr_t'(a);
			next_cycle();
		end
		end_test();

		begin_test("R0 load and readout");
		for (int i = 0; i < 6; i++) begin
			quiet_inputs();
			ctl.lpc = 1'b1;
			ctl.addr = rand_uaddr();
			w = rand_word();
			next_cycle();
			ctl.lpc = 1'b0;
			ctl.addr = 3'd0;
			next_cycle();
			ctl.addr = rand_uaddr();
			ctl.rpc = 1'b1; // Forced over a user address
			next_cycle();
			ctl.rpc = 1'b0;
			ctl.blr = 1'b1;
			next_cycle();
		end
		end_test();

		begin_test("flag updates");
		for (int i = 0; i < 48; i++) begin
			quiet_inputs();
			bits = take_bits(14);
			alu = bits[13:0];
			alu.aryt = i[0]; // Both compare modes
			v_clr = (take_bits(2) == 32'd0);
			next_cycle();
		end
		end_test();

		begin_test("R0 write protection");
		for (int p = 0; p < 2; p++) begin
			quiet_inputs();
			w = rand_word();
			w[10] = (p == 0); // Q set first and clear second
			ctl.w_bar = 1'b1;
			next_cycle();
			quiet_inputs();
			ctl.w_r = 1'b1;
			for (int i = 0; i < 12; i++) begin
				w = rand_word();
				bits = take_bits(14);
				alu = bits[13:0];
				next_cycle();
			end
		end
		end_test();

		begin_test("system flags and clears");
		ki_sel = KI_SR;
		for (int i = 0; i < 8; i++) begin
			quiet_inputs();
			bits = take_bits(10);
			rs = bits[9:0];
			w = rand_word();
			w[10] = 1'b1;
			ctl.w_bar = 1'b1;
			next_cycle();
			quiet_inputs();
			w = rand_word();
			ctl.lpc = 1'b1; // Something in R0 to clear
			next_cycle();
			quiet_inputs();
			if (i[0]) ctl.clm = 1'b1;
			else ctl.zer_sp = 1'b1;
			next_cycle();
		end
		quiet_inputs();
		next_cycle(); // Last master clear seen on KI
		end_test();

		begin_test("RB fields and KI sources");
		quiet_inputs();
		ki_sel = KI_RB;
		for (int i = 0; i < 24; i++) begin
			w = rand_word();
			bits = take_bits(3);
			ctl.w_rba = bits[0];
			ctl.w_rbb = bits[1];
			ctl.w_rbc = bits[2];
			next_cycle();
		end
		quiet_inputs();
		next_cycle(); // Last RB load seen on KI
		for (int i = 0; i < 16; i++) begin
			ki_sel = i[0] ? KI_ZP : KI_RZ;
			rz = rand_word();
			zp = rand_word();
			next_cycle();
		end
		end_test();

		checking = 1'b0;
		$display("%0d tests, %0d failed, %0d checks, %0d errors", test_cnt, test_fail_cnt,
			check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: files.f
rtl/pr_pkg.sv
rtl/ureg_write_dec.sv
rtl/ureg_word.sv
rtl/ureg_read_sel.sv
rtl/r0_flags.sv
rtl/sys_regs.sv
rtl/ki_bus.sv
rtl/pr.sv
test/pr_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the register unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f files.f --top-module pr_tb -o pr_sim
out=$(./obj_dir/pr_sim)
echo "$out"
if grep -qx "Test OK" <<< "$out"; then
	exit 0
fi
exit 1
